//--- source/sysmon_config.svh
`ifndef SYSMON_CONFIG_SVH
`define SYSMON_CONFIG_SVH

// host register addresses, one byte wide each
`define SYSMON_REG_DRP_ADDR     8'h30  // drp address, bit 7 = write
`define SYSMON_REG_DRP_DATA     8'h31  // drp data word, byte-wise
`define SYSMON_REG_STAT         8'h32  // held alarm flags

`define SYSMON_BYTECNT_SIZE     7      // byte index width on host bus

`define SYSMON_DRP_LATENCY      4      // den to drdy, in clk_usb cycles

// drp status slots, read only
`define SYSMON_DRP_TEMP         7'h00
`define SYSMON_DRP_VCCINT       7'h01
`define SYSMON_DRP_VCCAUX       7'h02
`define SYSMON_DRP_VBRAM        7'h06

// writable storage window
`define SYSMON_DRP_CFG_BASE     7'h40
`define SYSMON_DRP_CFG_LAST     7'h7F

// upper alarm thresholds
`define SYSMON_DRP_TEMP_UPPER   7'h50
`define SYSMON_DRP_VCCINT_UPPER 7'h51
`define SYSMON_DRP_VCCAUX_UPPER 7'h52
`define SYSMON_DRP_OT_UPPER     7'h53
`define SYSMON_DRP_VBRAM_UPPER  7'h58

// lower alarm thresholds
`define SYSMON_DRP_VCCINT_LOWER 7'h55
`define SYSMON_DRP_VCCAUX_LOWER 7'h56
`define SYSMON_DRP_VBRAM_LOWER  7'h5C

`endif

//--- source/reg_pkg.sv
`include "sysmon_config.svh"

// types of the host byte-register bus
package reg_pkg;

  // register select from host
  typedef logic [7:0] reg_addr_t;

  // one data byte, either direction
  typedef logic [7:0] reg_byte_t;

  // byte position inside a multi-byte register
  typedef logic [`SYSMON_BYTECNT_SIZE-1:0] reg_bytecnt_t;

endpackage

//--- source/sysmon_pkg.sv
// types shared across the drp link and the monitor model
package sysmon_pkg;

  typedef logic [6:0]  drp_addr_t;     // drp register address
  typedef logic [15:0] drp_data_t;     // drp data word
  typedef logic [11:0] sensor_code_t;  // raw conversion code, msb aligned in status word
  typedef logic [4:0]  alarm_vec_t;    // one bit per alarm source

  // alarm bit positions
  localparam int ALARM_OT        = 0;  // over-temperature
  localparam int ALARM_USER_TEMP = 1;  // user temperature
  localparam int ALARM_VCCINT    = 2;
  localparam int ALARM_VCCAUX    = 3;
  localparam int ALARM_VBRAM     = 4;

  // drp slave side of the model
  typedef enum logic {
    DRP_IDLE = 1'b0,  // accepting den
    DRP_BUSY = 1'b1   // counting latency, den dropped
  } drp_state_t;

endpackage

//--- source/sysmon_regs.sv
`timescale 1ns/100ps
`include "sysmon_config.svh"

module sysmon_regs (
  input  logic                  clk_usb,
  input  logic                  reset_i,
  input  reg_pkg::reg_addr_t    reg_address,  // host register select
  input  reg_pkg::reg_bytecnt_t reg_bytecnt,  // byte within register
  input  reg_pkg::reg_byte_t    reg_datai,    // host write byte
  input  logic                  reg_read,     // read level
  input  logic                  reg_write,    // write strobe, one cycle
  input  sysmon_pkg::drp_data_t drp_result,   // last drp response word
  input  logic                  drp_pending,  // request outstanding
  input  sysmon_pkg::alarm_vec_t alarms,      // transient alarms from monitor
  output reg_pkg::reg_byte_t    reg_datao,    // host read byte
  output sysmon_pkg::drp_addr_t drp_addr,
  output sysmon_pkg::drp_data_t drp_din,
  output logic                  drp_den,
  output logic                  drp_dwe,
  output logic                  xadc_error
);
  import reg_pkg::*;
  import sysmon_pkg::*;

  alarm_vec_t alarm_hold;       // sticky alarm flags
  alarm_vec_t alarm_hold_next;
  logic       stat_clear;       // host write to STAT
  logic       addr_write;       // host write to DRP_ADDR, fires a request
  logic       data_write;       // host write to DRP_DATA

  // pick one byte of a drp word, out of range bytes read zero
  function automatic reg_byte_t word_byte(input drp_data_t word, input reg_bytecnt_t idx);
    reg_byte_t b;
    case (idx)
      reg_bytecnt_t'(0): b = word[7:0];
      reg_bytecnt_t'(1): b = word[15:8];
      default:           b = '0;
    endcase
    return b;
  endfunction

  assign stat_clear = reg_write && (reg_address == `SYSMON_REG_STAT);
  assign addr_write = reg_write && (reg_address == `SYSMON_REG_DRP_ADDR);
  assign data_write = reg_write && (reg_address == `SYSMON_REG_DRP_DATA);

  // host read mux, combinational
  always_comb begin
    reg_datao = '0;
    if (reg_read) begin
      case (reg_address)
        `SYSMON_REG_DRP_ADDR: reg_datao = {drp_pending, drp_addr};  // poll bit on top
        `SYSMON_REG_DRP_DATA: reg_datao = word_byte(drp_result, reg_bytecnt);
        `SYSMON_REG_STAT:     reg_datao = {3'b000, alarm_hold};
        default:              reg_datao = '0;  // unmapped
      endcase
    end
  end

  // pending write word, built byte by byte
  always_ff @(posedge clk_usb) begin
    if (data_write) begin
      case (reg_bytecnt)
        reg_bytecnt_t'(0): drp_din[7:0]  <= reg_datai;
        reg_bytecnt_t'(1): drp_din[15:8] <= reg_datai;
        default: ;  // bytes past the word ignored
      endcase
    end
  end

  // drp address latched with the request
  always_ff @(posedge clk_usb) begin
    if (addr_write) begin
      drp_addr <= reg_datai[6:0];
    end
  end

  // single-cycle request, one cycle after the host write
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      drp_den <= 1'b0;
      drp_dwe <= 1'b0;
    end else begin
      drp_den <= addr_write;
      drp_dwe <= addr_write && reg_datai[7];  // msb selects write
    end
  end

  // clear has priority, a live alarm sets again next cycle
  assign alarm_hold_next = stat_clear ? '0 : (alarm_hold | alarms);

  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      alarm_hold <= '0;
      xadc_error <= 1'b0;
    end else begin
      alarm_hold <= alarm_hold_next;
      xadc_error <= |alarm_hold_next;  // tracks held flags same cycle
    end
  end

endmodule

//--- source/drp_read_buffer.sv
`timescale 1ns/100ps

module drp_read_buffer (
  input  logic                  clk_usb,
  input  logic                  reset_i,
  input  logic                  drp_den,     // request start
  input  logic                  drp_drdy,    // response pulse from monitor
  input  sysmon_pkg::drp_data_t drp_dout,    // response word, valid with drdy
  output sysmon_pkg::drp_data_t drp_result,  // held copy for host reads
  output logic                  drp_pending  // set from den to drdy
);

  // drdy lasts one cycle, keep the word until the next response
  always_ff @(posedge clk_usb) begin
    if (drp_drdy) begin
      drp_result <= drp_dout;
    end
  end

  // outstanding request flag
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      drp_pending <= 1'b0;
    end else if (drp_den) begin
      drp_pending <= 1'b1;  // new request, even on top of a pending one
    end else if (drp_drdy) begin
      drp_pending <= 1'b0;  // result word valid from here
    end
  end

endmodule

//--- source/sysmon_model.sv
`timescale 1ns/100ps
`include "sysmon_config.svh"

module sysmon_model (
  input  logic                     clk_usb,
  input  logic                     reset_i,
  input  sysmon_pkg::drp_addr_t    drp_addr,
  input  sysmon_pkg::drp_data_t    drp_din,
  input  logic                     drp_den,
  input  logic                     drp_dwe,
  input  sysmon_pkg::sensor_code_t temp_code,
  input  sysmon_pkg::sensor_code_t vccint_code,
  input  sysmon_pkg::sensor_code_t vccaux_code,
  input  sysmon_pkg::sensor_code_t vbram_code,
  output sysmon_pkg::drp_data_t    drp_dout,
  output logic                     drp_drdy,
  output sysmon_pkg::alarm_vec_t   alarms
);
  import sysmon_pkg::*;

  localparam int LAT_CNT_W = $clog2(`SYSMON_DRP_LATENCY);

  drp_state_t           state;
  logic [LAT_CNT_W-1:0] lat_cnt;    // cycles left before drdy
  logic                 req_done;   // last busy cycle
  drp_addr_t            req_addr;   // request captured at den
  drp_data_t            req_din;
  logic                 req_dwe;
  drp_data_t            rd_word;
  drp_data_t            temp_word;  // codes placed in upper 12 bits
  drp_data_t            vccint_word;
  drp_data_t            vccaux_word;
  drp_data_t            vbram_word;
  drp_data_t            stat_temp;  // status slots
  drp_data_t            stat_vccint;
  drp_data_t            stat_vccaux;
  drp_data_t            stat_vbram;
  drp_data_t            cfg_mem [`SYSMON_DRP_CFG_BASE:`SYSMON_DRP_CFG_LAST];

  // thresholds open wide out of reset, so nothing trips
  function automatic drp_data_t cfg_reset_word(input drp_addr_t addr);
    drp_data_t w;
    case (addr)
      `SYSMON_DRP_TEMP_UPPER, `SYSMON_DRP_VCCINT_UPPER, `SYSMON_DRP_VCCAUX_UPPER,
      `SYSMON_DRP_OT_UPPER, `SYSMON_DRP_VBRAM_UPPER: w = '1;
      default: w = '0;  // lower thresholds and spare storage
    endcase
    return w;
  endfunction

  assign temp_word   = {temp_code, 4'h0};
  assign vccint_word = {vccint_code, 4'h0};
  assign vccaux_word = {vccaux_code, 4'h0};
  assign vbram_word  = {vbram_code, 4'h0};

  // sensors sampled every cycle
  always_ff @(posedge clk_usb) begin
    stat_temp   <= temp_word;
    stat_vccint <= vccint_word;
    stat_vccaux <= vccaux_word;
    stat_vbram  <= vbram_word;
  end

  // drp slave fsm, den while busy is dropped
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      state    <= DRP_IDLE;
      lat_cnt  <= '0;
      drp_drdy <= 1'b0;
    end else begin
      drp_drdy <= 1'b0;
      case (state)
        DRP_IDLE: if (drp_den) begin
          state   <= DRP_BUSY;
          lat_cnt <= LAT_CNT_W'(`SYSMON_DRP_LATENCY - 2);  // drdy lands latency after den
        end
        DRP_BUSY: if (req_done) begin
          state    <= DRP_IDLE;
          drp_drdy <= 1'b1;
        end else begin
          lat_cnt <= lat_cnt - 1'b1;
        end
        default: state <= DRP_IDLE;
      endcase
    end
  end

  assign req_done = (state == DRP_BUSY) && (lat_cnt == '0);

  always_ff @(posedge clk_usb) begin
    if ((state == DRP_IDLE) && drp_den) begin
      req_addr <= drp_addr;
      req_din  <= drp_din;
      req_dwe  <= drp_dwe;
    end
  end

  // read side, status slots below 0x40, storage above
  always_comb begin
    rd_word = '0;
    if (req_addr[6]) begin
      rd_word = cfg_mem[req_addr];
    end else begin
      case (req_addr)
        `SYSMON_DRP_TEMP:   rd_word = stat_temp;
        `SYSMON_DRP_VCCINT: rd_word = stat_vccint;
        `SYSMON_DRP_VCCAUX: rd_word = stat_vccaux;
        `SYSMON_DRP_VBRAM:  rd_word = stat_vbram;
        default:            rd_word = '0;  // unused read-only slots
      endcase
    end
  end

  always_ff @(posedge clk_usb) begin
    if (req_done) begin
      drp_dout <= rd_word;  // presented with drdy
    end
  end

  // storage, write lands in the drdy cycle, status slots not writable
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      for (int i = `SYSMON_DRP_CFG_BASE; i <= `SYSMON_DRP_CFG_LAST; i++) begin
        cfg_mem[i] <= cfg_reset_word(drp_addr_t'(i));
      end
    end else if (req_done && req_dwe && req_addr[6]) begin
      cfg_mem[req_addr] <= req_din;
    end
  end

  // alarm compare, one cycle behind code or threshold
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      alarms <= '0;
    end else begin
      alarms[ALARM_OT]        <= temp_word > cfg_mem[`SYSMON_DRP_OT_UPPER];
      alarms[ALARM_USER_TEMP] <= temp_word > cfg_mem[`SYSMON_DRP_TEMP_UPPER];
      alarms[ALARM_VCCINT]    <= (vccint_word > cfg_mem[`SYSMON_DRP_VCCINT_UPPER]) ||
                                 (vccint_word < cfg_mem[`SYSMON_DRP_VCCINT_LOWER]);
      alarms[ALARM_VCCAUX]    <= (vccaux_word > cfg_mem[`SYSMON_DRP_VCCAUX_UPPER]) ||
                                 (vccaux_word < cfg_mem[`SYSMON_DRP_VCCAUX_LOWER]);
      alarms[ALARM_VBRAM]     <= (vbram_word > cfg_mem[`SYSMON_DRP_VBRAM_UPPER]) ||
                                 (vbram_word < cfg_mem[`SYSMON_DRP_VBRAM_LOWER]);
    end
  end

endmodule

//--- source/sysmon_top.sv
`timescale 1ns/100ps

module sysmon_top (
  input  logic                     clk_usb,
  input  logic                     reset_i,
  input  reg_pkg::reg_addr_t       reg_address,  // host bus
  input  reg_pkg::reg_bytecnt_t    reg_bytecnt,
  input  reg_pkg::reg_byte_t       reg_datai,
  input  logic                     reg_read,
  input  logic                     reg_write,
  input  sysmon_pkg::sensor_code_t temp_code,    // sensor codes into the model
  input  sysmon_pkg::sensor_code_t vccint_code,
  input  sysmon_pkg::sensor_code_t vccaux_code,
  input  sysmon_pkg::sensor_code_t vbram_code,
  output reg_pkg::reg_byte_t       reg_datao,
  output logic                     xadc_error    // any held alarm
);
  import sysmon_pkg::*;

  drp_addr_t  drp_addr;
  drp_data_t  drp_din;
  logic       drp_den;
  logic       drp_dwe;
  drp_data_t  drp_dout;
  logic       drp_drdy;
  drp_data_t  drp_result;   // buffered response
  logic       drp_pending;
  alarm_vec_t alarms;       // raw, not yet held

  sysmon_regs u_sysmon_regs (
    .clk_usb     (clk_usb),
    .reset_i     (reset_i),
    .reg_address (reg_address),
    .reg_bytecnt (reg_bytecnt),
    .reg_datai   (reg_datai),
    .reg_read    (reg_read),
    .reg_write   (reg_write),
    .drp_result  (drp_result),
    .drp_pending (drp_pending),
    .alarms      (alarms),
    .reg_datao   (reg_datao),
    .drp_addr    (drp_addr),
    .drp_din     (drp_din),
    .drp_den     (drp_den),
    .drp_dwe     (drp_dwe),
    .xadc_error  (xadc_error)
  );

  drp_read_buffer u_drp_read_buffer (
    .clk_usb     (clk_usb),
    .reset_i     (reset_i),
    .drp_den     (drp_den),
    .drp_drdy    (drp_drdy),
    .drp_dout    (drp_dout),
    .drp_result  (drp_result),
    .drp_pending (drp_pending)
  );

  sysmon_model u_sysmon_model (
    .clk_usb     (clk_usb),
    .reset_i     (reset_i),
    .drp_addr    (drp_addr),
    .drp_din     (drp_din),
    .drp_den     (drp_den),
    .drp_dwe     (drp_dwe),
    .temp_code   (temp_code),
    .vccint_code (vccint_code),
    .vccaux_code (vccaux_code),
    .vbram_code  (vbram_code),
    .drp_dout    (drp_dout),
    .drp_drdy    (drp_drdy),
    .alarms      (alarms)
  );

endmodule

//--- testbench/sysmon_top_assert.sv
`timescale 1ns/100ps
`include "sysmon_config.svh"

module sysmon_top_assert #(
  parameter bit MODEL_SIDE = 1'b1  // set on the drp slave and clear on the host slice
) (
  input logic                   clk_usb,
  input logic                   reset_i,
  input logic                   drp_den,
  input logic                   drp_drdy,
  input logic                   drp_pending,
  input sysmon_pkg::alarm_vec_t alarm_hold,
  input logic                   xadc_error
);

  int unsigned fail_count = 0;  // failed assertions so far

  drdy_single_pulse: assert property (@(posedge clk_usb) disable iff (reset_i || !MODEL_SIDE)
    drp_drdy |=> !drp_drdy)
    else begin
      $error("drdy stayed high for more than one cycle");
      fail_count++;
    end

  // fixed response latency checked both ways
  den_to_drdy: assert property (@(posedge clk_usb) disable iff (reset_i || !MODEL_SIDE)
    drp_den |-> ##(`SYSMON_DRP_LATENCY) drp_drdy)
    else begin
      $error("drdy missing at the expected latency after den");
      fail_count++;
    end

  drdy_from_den: assert property (@(posedge clk_usb) disable iff (reset_i || !MODEL_SIDE)
    drp_drdy |-> $past(drp_den, `SYSMON_DRP_LATENCY))
    else begin
      $error("drdy without a den at the expected latency");
      fail_count++;
    end

  no_den_while_pending: assert property (@(posedge clk_usb) disable iff (reset_i || MODEL_SIDE)
    drp_pending |-> !drp_den)
    else begin
      $error("DRP request issued while another one is pending");
      fail_count++;
    end

  xadc_matches_hold: assert property (@(posedge clk_usb) disable iff (reset_i || MODEL_SIDE)
    xadc_error == |alarm_hold)
    else begin
      $error("xadc_error differs from the OR of the held alarms");
      fail_count++;
    end

endmodule

bind sysmon_model sysmon_top_assert #(.MODEL_SIDE(1'b1)) u_model_assert (
  .clk_usb     (clk_usb),
  .reset_i     (reset_i),
  .drp_den     (drp_den),
  .drp_drdy    (drp_drdy),
  .drp_pending (1'b0),
  .alarm_hold  (5'b00000),
  .xadc_error  (1'b0)
);

bind sysmon_regs sysmon_top_assert #(.MODEL_SIDE(1'b0)) u_regs_assert (
  .clk_usb     (clk_usb),
  .reset_i     (reset_i),
  .drp_den     (drp_den),
  .drp_drdy    (1'b0),
  .drp_pending (drp_pending),
  .alarm_hold  (alarm_hold),
  .xadc_error  (xadc_error)
);

//--- testbench/sysmon_top_tb.sv
`timescale 1ns/100ps
`include "sysmon_config.svh"

module sysmon_top_tb;
  import reg_pkg::*;
  import sysmon_pkg::*;

  localparam int POLL_LIMIT = 20;  // host polls before giving up
  localparam int MAX_ENTRIES = 16;

  logic         clk_usb;
  logic         reset_i;
  reg_addr_t    reg_address;
  reg_bytecnt_t reg_bytecnt;
  reg_byte_t    reg_datai;
  logic         reg_read;
  logic         reg_write;
  sensor_code_t temp_code;
  sensor_code_t vccint_code;
  sensor_code_t vccaux_code;
  sensor_code_t vbram_code;
  reg_byte_t    reg_datao;
  logic         xadc_error;

  // stimulus table with one column per field
  string        e_name     [MAX_ENTRIES];
  drp_addr_t    e_addr     [MAX_ENTRIES];
  logic         e_wr       [MAX_ENTRIES];
  drp_data_t    e_wdata    [MAX_ENTRIES];
  sensor_code_t e_temp     [MAX_ENTRIES];
  sensor_code_t e_vccint   [MAX_ENTRIES];
  sensor_code_t e_vccaux   [MAX_ENTRIES];
  sensor_code_t e_vbram    [MAX_ENTRIES];
  drp_data_t    e_exp_rd   [MAX_ENTRIES];  // only for reads
  alarm_vec_t   e_exp_stat [MAX_ENTRIES];  // held alarms after the access
  int           n_entries = 0;

  sysmon_top u_sysmon_top (
    .clk_usb     (clk_usb),
    .reset_i     (reset_i),
    .reg_address (reg_address),
    .reg_bytecnt (reg_bytecnt),
    .reg_datai   (reg_datai),
    .reg_read    (reg_read),
    .reg_write   (reg_write),
    .temp_code   (temp_code),
    .vccint_code (vccint_code),
    .vccaux_code (vccaux_code),
    .vbram_code  (vbram_code),
    .reg_datao   (reg_datao),
    .xadc_error  (xadc_error)
  );

  initial begin
    clk_usb = 1'b0;
    forever #4 clk_usb = ~clk_usb;  // 8 ns period
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "stopping on first error");
  endtask

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic add_entry(input string name, input drp_addr_t addr, input logic wr,
                           input drp_data_t wdata, input sensor_code_t t,
                           input sensor_code_t vi, input sensor_code_t va,
                           input sensor_code_t vb, input drp_data_t exp_rd,
                           input alarm_vec_t exp_stat);
    e_name[n_entries]     = name;
    e_addr[n_entries]     = addr;
    e_wr[n_entries]       = wr;
    e_wdata[n_entries]    = wdata;
    e_temp[n_entries]     = t;
    e_vccint[n_entries]   = vi;
    e_vccaux[n_entries]   = va;
    e_vbram[n_entries]    = vb;
    e_exp_rd[n_entries]   = exp_rd;
    e_exp_stat[n_entries] = exp_stat;
    n_entries++;
  endtask

  // one-cycle write strobe driven on the falling edge
  task automatic write_reg(input reg_addr_t addr, input reg_bytecnt_t idx, input reg_byte_t data);
    @(negedge clk_usb);
    reg_address = addr;
    reg_bytecnt = idx;
    reg_datai   = data;
    reg_read    = 1'b0;
    reg_write   = 1'b1;
    @(negedge clk_usb);
    reg_write   = 1'b0;
  endtask

  // combinational read path sampled in the low phase
  task automatic read_reg(input reg_addr_t addr, input reg_bytecnt_t idx, output reg_byte_t data);
    @(negedge clk_usb);
    reg_address = addr;
    reg_bytecnt = idx;
    reg_read    = 1'b1;
    #2;
    data = reg_datao;
  endtask

  task automatic drp_access(input drp_addr_t addr, input logic wr, input drp_data_t wdata,
                            output drp_data_t rd_word);
    reg_byte_t b;
    reg_byte_t lo;
    reg_byte_t hi;
    logic      seen;
    if (wr) begin
      write_reg(`SYSMON_REG_DRP_DATA, reg_bytecnt_t'(0), wdata[7:0]);
      write_reg(`SYSMON_REG_DRP_DATA, reg_bytecnt_t'(1), wdata[15:8]);
    end
    write_reg(`SYSMON_REG_DRP_ADDR, reg_bytecnt_t'(0), {wr, addr});  // bit 7 = write
    seen = 1'b0;
    for (int i = 0; i < POLL_LIMIT && !seen; i++) begin
      read_reg(`SYSMON_REG_DRP_ADDR, reg_bytecnt_t'(0), b);
      seen = b[7];
    end
    if (!seen) abort_run("pending flag never set after the DRP request");
    for (int i = 0; i < POLL_LIMIT && seen; i++) begin
      read_reg(`SYSMON_REG_DRP_ADDR, reg_bytecnt_t'(0), b);
      seen = b[7];
    end
    if (seen) abort_run("DRP request still pending after the poll limit");
    check_value("drp address echo", 16'(addr), 16'(b[6:0]));
    read_reg(`SYSMON_REG_DRP_DATA, reg_bytecnt_t'(0), lo);
    read_reg(`SYSMON_REG_DRP_DATA, reg_bytecnt_t'(1), hi);
    rd_word = {hi, lo};
  endtask

  // stop as soon as a bound assertion has failed
  always @(negedge clk_usb) begin
    if (u_sysmon_top.u_sysmon_model.u_model_assert.fail_count != 0 ||
        u_sysmon_top.u_sysmon_regs.u_regs_assert.fail_count != 0) begin
      abort_run("a bound DRP or alarm assertion failed");
    end
  end

  initial begin
    sensor_code_t t;
    sensor_code_t vi;
    sensor_code_t va;
    sensor_code_t vb;
    drp_data_t    spare;
    drp_data_t    rd_word;
    reg_byte_t    b;
    void'($urandom(10));
    t     = sensor_code_t'($urandom) | 12'h001;  // nonzero so a zero threshold trips
    vi    = sensor_code_t'($urandom);
    va    = sensor_code_t'($urandom);
    vb    = sensor_code_t'($urandom);
    spare = drp_data_t'($urandom);
    reset_i     = 1'b1;
    reg_address = '0;
    reg_bytecnt = '0;
    reg_datai   = '0;
    reg_read    = 1'b0;
    reg_write   = 1'b0;
    temp_code   = t;
    vccint_code = vi;
    vccaux_code = va;
    vbram_code  = vb;

    // status words carry the code in bits 15..4
    add_entry("rd temp status", 7'h00, 1'b0, 16'h0, t, vi, va, vb, {t, 4'h0}, 5'h00);
    add_entry("rd vccint status", 7'h01, 1'b0, 16'h0, t, vi, va, vb, {vi, 4'h0}, 5'h00);
    add_entry("rd vccaux status", 7'h02, 1'b0, 16'h0, t, vi, va, vb, {va, 4'h0}, 5'h00);
    add_entry("rd vbram status", 7'h06, 1'b0, 16'h0, t, vi, va, vb, {vb, 4'h0}, 5'h00);
    add_entry("rd ot upper reset", 7'h53, 1'b0, 16'h0, t, vi, va, vb, 16'hFFFF, 5'h00);
    add_entry("rd vccint lower reset", 7'h55, 1'b0, 16'h0, t, vi, va, vb, 16'h0000, 5'h00);
    add_entry("wr spare", 7'h40, 1'b1, spare, t, vi, va, vb, 16'h0, 5'h00);
    add_entry("rd spare", 7'h40, 1'b0, 16'h0, t, vi, va, vb, spare, 5'h00);
    add_entry("wr vbram upper", 7'h58, 1'b1, 16'hFFF5, t, vi, va, vb, 16'h0, 5'h00);  // above any code
    add_entry("rd vbram upper", 7'h58, 1'b0, 16'h0, t, vi, va, vb, 16'hFFF5, 5'h00);
    add_entry("wr temp status", 7'h00, 1'b1, 16'h1234, t, vi, va, vb, 16'h0, 5'h00);
    add_entry("rd temp after write", 7'h00, 1'b0, 16'h0, t, vi, va, vb, {t, 4'h0}, 5'h00);
    add_entry("wr temp upper", 7'h50, 1'b1, 16'h0000, t, vi, va, vb, 16'h0, 5'h02);
    add_entry("wr ot upper", 7'h53, 1'b1, 16'h0000, t, vi, va, vb, 16'h0, 5'h03);
    add_entry("wr vccint lower", 7'h55, 1'b1, 16'hFFFF, t, vi, va, vb, 16'h0, 5'h07);
    add_entry("rd temp cooled", 7'h00, 1'b0, 16'h0, 12'h000, vi, va, vb, 16'h0000, 5'h07);

    repeat (10) @(negedge clk_usb);
    reset_i = 1'b0;

    check_value("reset xadc_error", 16'h0, 16'(xadc_error));
    read_reg(`SYSMON_REG_STAT, reg_bytecnt_t'(0), b);
    check_value("reset stat", 16'h0, 16'(b));
    read_reg(`SYSMON_REG_DRP_ADDR, reg_bytecnt_t'(0), b);
    check_value("reset pending flag", 16'h0, 16'(b[7]));

    for (int i = 0; i < n_entries; i++) begin
      @(negedge clk_usb);
      temp_code   = e_temp[i];
      vccint_code = e_vccint[i];
      vccaux_code = e_vccaux[i];
      vbram_code  = e_vbram[i];
      drp_access(e_addr[i], e_wr[i], e_wdata[i], rd_word);
      if (!e_wr[i]) check_value({e_name[i], " read word"}, e_exp_rd[i], rd_word);
      read_reg(`SYSMON_REG_STAT, reg_bytecnt_t'(0), b);
      check_value({e_name[i], " stat"}, 16'(e_exp_stat[i]), 16'(b));
      check_value({e_name[i], " xadc_error"}, 16'(|e_exp_stat[i]), 16'(xadc_error));
    end

    // vccint alarm is still live and comes back after the clear
    write_reg(`SYSMON_REG_STAT, reg_bytecnt_t'(0), 8'hFF);
    read_reg(`SYSMON_REG_STAT, reg_bytecnt_t'(0), b);
    check_value("stat after clear", 16'h0004, 16'(b));
    check_value("xadc_error after clear", 16'h1, 16'(xadc_error));

    @(negedge clk_usb);
    reg_address = `SYSMON_REG_STAT;
    reg_read    = 1'b0;  // bus reads zero even with held alarms set
    #2;
    check_value("read level low", 16'h0, 16'(reg_datao));
    read_reg(8'h33, reg_bytecnt_t'(0), b);
    check_value("unknown address", 16'h0, 16'(b));

    $display("Testbench passed");
    $finish;
  end

endmodule

//--- files.f
+incdir+source
source/reg_pkg.sv
source/sysmon_pkg.sv
source/sysmon_regs.sv
source/drp_read_buffer.sv
source/sysmon_model.sv
source/sysmon_top.sv
testbench/sysmon_top_assert.sv
testbench/sysmon_top_tb.sv

//--- Bender.yml
package:
  name: sysmon_drp_bridge

export_include_dirs:
  - source

sources:
  - files:
      - source/reg_pkg.sv
      - source/sysmon_pkg.sv
      - source/sysmon_regs.sv
      - source/drp_read_buffer.sv
      - source/sysmon_model.sv
      - source/sysmon_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/sysmon_top_assert.sv
      - testbench/sysmon_top_tb.sv
